/* isa_pkg.sv */
package isa_pkg;

    // Word registers in ModRM encoding order
    typedef enum logic [2:0] {
        AW = 3'd0,
        CW = 3'd1,
        DW = 3'd2,
        BW = 3'd3,
        SP = 3'd4,
        BP = 3'd5,
        IX = 3'd6,
        IY = 3'd7
    } reg16_e;

    // Bit 2 picks the high byte, bits 1:0 the word register
    typedef enum logic [2:0] {
        AL = 3'd0,
        CL = 3'd1,
        DL = 3'd2,
        BL = 3'd3,
        AH = 3'd4,
        CH = 3'd5,
        DH = 3'd6,
        BH = 3'd7
    } reg8_e;

    // First eight follow opcode bits 5:3 of the ALU group
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_OR     = 4'd1,
        ALU_ADDC   = 4'd2,
        ALU_SUBC   = 4'd3,
        ALU_AND    = 4'd4,
        ALU_SUB    = 4'd5,
        ALU_XOR    = 4'd6,
        ALU_CMP    = 4'd7,
        ALU_PASS   = 4'd8,
        ALU_NOT_CY = 4'd9,
        ALU_CLR_CY = 4'd10,
        ALU_SET_CY = 4'd11,
        ALU_CVTBW  = 4'd12,
        ALU_CVTWL  = 4'd13
    } alu_op_e;

    // MSB first, same relative order as in the PSW
    typedef struct packed {
        logic v;
        logic s;
        logic z;
        logic ac;
        logic p;
        logic cy;
    } flags_t;

    typedef struct packed {
        logic [7:0]  opcode;
        logic [7:0]  modrm;
        logic [15:0] imm;
    } instr_t;

    typedef logic [7:0][15:0] regfile_t;   // Indexed by reg16_e

    localparam logic [5:0] OP_MOV_RM  = 6'b100010;  // 88h..8Bh
    localparam logic [3:0] OP_MOV_IMM = 4'hb;       // B0h..BFh
    localparam logic [7:0] OP_NOT1_CY = 8'hf5;
    localparam logic [7:0] OP_CLR1_CY = 8'hf8;
    localparam logic [7:0] OP_SET1_CY = 8'hf9;
    localparam logic [7:0] OP_CVTBW   = 8'h98;
    localparam logic [7:0] OP_CVTWL   = 8'h99;

endpackage

/* pipe_pkg.sv */
package pipe_pkg;

    import isa_pkg::*;

    // Decode to execute
    typedef struct packed {
        alu_op_e     op;
        logic        wide;
        logic [15:0] a;
        logic [15:0] b;          // Register or zero-extended immediate
        reg16_e      dest;
        logic        writes_reg;
        logic        high;       // Byte write to bits 15:8
        logic        writes_flags;
        flags_t      flags;      // Flag word at decode time
    } dec_item_t;

    // Execute to result
    typedef struct packed {
        reg16_e      dest;
        logic        writes_reg;
        logic        wide;
        logic        high;
        logic        writes_flags;
        logic [15:0] data;       // Byte results sit in 7:0
        flags_t      flags;
    } exec_item_t;

    // One record per retired instruction
    typedef struct packed {
        logic        valid;
        logic        writes_reg;
        reg16_e      dest;
        logic [15:0] data;       // Whole word after the merge
        flags_t      flags;
    } retire_t;

endpackage

/* pipe_stage.sv */
module pipe_stage
    import pipe_pkg::*;
#(
    parameter type payload_t = dec_item_t
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // Payload only moves with a valid item
    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_data <= in_data;
        end
    end

endmodule

/* instr_decode.sv */
module instr_decode
    import isa_pkg::*, pipe_pkg::*;
(
    input  instr_t    instr,
    input  logic      op_valid,
    output logic      op_ready,
    input  regfile_t  regs,
    input  flags_t    flags,
    input  logic      x_valid,
    input  reg16_e    x_dest,
    input  logic      x_flags,
    input  logic      r_valid,
    input  reg16_e    r_dest,
    input  logic      r_flags,
    output logic      dec_valid,
    output dec_item_t dec
);

    logic [7:0] opc;
    logic [2:0] reg_f;
    logic [2:0] rm;
    logic       is_alu, is_mov_rm, is_mov_imm;
    logic       legal, uses_modrm, use_a, use_b, imm_b, reads_flags;
    logic [2:0] a_idx, b_idx, d_idx;   // Byte or word index, per width
    reg16_e     src_a, src_b;
    logic       hit_a, hit_b, hit_flags;

    // Word register that holds a byte or word operand
    function automatic reg16_e home(logic [2:0] idx, logic wide);
        reg8_e r8;
        r8 = reg8_e'(idx);
        return wide ? reg16_e'(idx) : reg16_e'({1'b0, r8[1:0]});
    endfunction

    function automatic logic [15:0] read_reg(regfile_t rf, logic [2:0] idx, logic wide);
        logic [15:0] word;
        word = rf[home(idx, wide)];
        if (wide) return word;
        return {8'h00, idx[2] ? word[15:8] : word[7:0]};
    endfunction

    assign opc   = instr.opcode;
    assign reg_f = instr.modrm[5:3];
    assign rm    = instr.modrm[2:0];

    assign is_alu     = opc[7:6] == 2'b00 && opc[2:1] != 2'b11;
    assign is_mov_rm  = opc[7:2] == OP_MOV_RM;
    assign is_mov_imm = opc[7:4] == OP_MOV_IMM;

    always_comb begin
        dec = '0;
        dec.flags = flags;
        legal = 1'b1;
        uses_modrm = 1'b0;
        use_a = 1'b0;
        use_b = 1'b0;
        imm_b = 1'b0;
        reads_flags = 1'b0;
        a_idx = AL;
        b_idx = AL;
        d_idx = AL;

        if (is_alu) begin
            dec.op = alu_op_e'({1'b0, opc[5:3]});
            dec.wide = opc[0];
            dec.writes_reg = dec.op != ALU_CMP;
            dec.writes_flags = 1'b1;
            reads_flags = dec.op inside {ALU_ADDC, ALU_SUBC};
            use_a = 1'b1;
            if (opc[2]) begin
                imm_b = 1'b1;                  // AL/AW, imm
            end else begin
                uses_modrm = 1'b1;
                use_b = 1'b1;
                a_idx = opc[1] ? reg_f : rm;   // Direction bit
                b_idx = opc[1] ? rm : reg_f;
                d_idx = a_idx;
            end
        end else if (is_mov_rm) begin
            dec.op = ALU_PASS;
            dec.wide = opc[0];
            dec.writes_reg = 1'b1;
            uses_modrm = 1'b1;
            use_b = 1'b1;
            b_idx = opc[1] ? rm : reg_f;
            d_idx = opc[1] ? reg_f : rm;
        end else if (is_mov_imm) begin
            dec.op = ALU_PASS;
            dec.wide = opc[3];
            dec.writes_reg = 1'b1;
            imm_b = 1'b1;
            d_idx = opc[2:0];
        end else begin
            // Flag ops merge into the whole flag word, so they wait on any flag write
            case (opc)
                OP_NOT1_CY: dec.op = ALU_NOT_CY;
                OP_CLR1_CY: dec.op = ALU_CLR_CY;
                OP_SET1_CY: dec.op = ALU_SET_CY;
                OP_CVTBW:   dec.op = ALU_CVTBW;
                OP_CVTWL:   dec.op = ALU_CVTWL;
                default:    legal = 1'b0;
            endcase
            if (opc == OP_CVTBW || opc == OP_CVTWL) begin
                dec.wide = 1'b1;
                dec.writes_reg = 1'b1;
                use_a = 1'b1;
                a_idx = AW;
                d_idx = opc[0] ? DW : AW;
            end else if (legal) begin
                dec.writes_flags = 1'b1;
                reads_flags = 1'b1;
            end
        end

        dec.a = read_reg(regs, a_idx, dec.wide);
        if (imm_b) begin
            dec.b = dec.wide ? instr.imm : {8'h00, instr.imm[7:0]};
        end else begin
            dec.b = read_reg(regs, b_idx, dec.wide);
        end
        dec.dest = home(d_idx, dec.wide);
        dec.high = !dec.wide && d_idx[2];
    end

    assign src_a = home(a_idx, dec.wide);
    assign src_b = home(b_idx, dec.wide);

    // In-flight destinations count even for CMP, which only costs a stall
    assign hit_a = use_a && ((x_valid && x_dest == src_a) || (r_valid && r_dest == src_a));
    assign hit_b = use_b && ((x_valid && x_dest == src_b) || (r_valid && r_dest == src_b));
    assign hit_flags = reads_flags && ((x_valid && x_flags) || (r_valid && r_flags));

    assign op_ready  = !(hit_a || hit_b || hit_flags);
    assign dec_valid = op_valid && op_ready;

    always_comb begin
        if (dec_valid) begin
            assert final (legal)
                else $error("Opcode %h outside the supported set", opc);
            assert final (!uses_modrm || instr.modrm[7:6] == 2'b11)
                else $error("Memory operand in ModRM %h", instr.modrm);
        end
    end

endmodule

/* alu_exec.sv */
module alu_exec
    import isa_pkg::*, pipe_pkg::*;
(
    input  logic       in_valid,
    input  dec_item_t  in,
    output logic       out_valid,
    output exec_item_t out
);

    logic        sub, cin;
    logic [16:0] sum;
    logic        a_s, b_s, r_s;
    logic [15:0] res;
    flags_t      f;

    assign sub = in.op inside {ALU_SUB, ALU_SUBC, ALU_CMP};
    assign cin = (in.op == ALU_ADDC || in.op == ALU_SUBC) && in.flags.cy;

    // Byte operands arrive zero-extended, so bit 8 is the byte carry or borrow
    always_comb begin
        if (sub) begin
            sum = {1'b0, in.a} - {1'b0, in.b} - {16'd0, cin};
        end else begin
            sum = {1'b0, in.a} + {1'b0, in.b} + {16'd0, cin};
        end
    end

    always_comb begin
        case (in.op)
            ALU_OR:    res = in.a | in.b;
            ALU_AND:   res = in.a & in.b;
            ALU_XOR:   res = in.a ^ in.b;
            ALU_PASS:  res = in.b;
            ALU_CVTBW: res = {{8{in.a[7]}}, in.a[7:0]};
            ALU_CVTWL: res = {16{in.a[15]}};
            default:   res = sum[15:0];
        endcase
        if (!in.wide) begin
            res = {8'h00, res[7:0]};
        end
    end

    assign a_s = in.wide ? in.a[15] : in.a[7];
    assign b_s = in.wide ? in.b[15] : in.b[7];
    assign r_s = in.wide ? res[15] : res[7];

    always_comb begin
        f = in.flags;
        case (in.op)
            ALU_ADD, ALU_ADDC, ALU_SUB, ALU_SUBC, ALU_CMP: begin
                f.cy = in.wide ? sum[16] : sum[8];
                f.ac = in.a[4] ^ in.b[4] ^ sum[4];
                f.v  = sub ? (a_s != b_s) && (r_s != a_s) : (a_s == b_s) && (r_s != a_s);
            end
            ALU_OR, ALU_AND, ALU_XOR: begin
                f.cy = 1'b0;
                f.ac = 1'b0;
                f.v  = 1'b0;
            end
            ALU_NOT_CY: f.cy = !in.flags.cy;
            ALU_CLR_CY: f.cy = 1'b0;
            ALU_SET_CY: f.cy = 1'b1;
            default: ;
        endcase
        if (in.op inside {[ALU_ADD:ALU_CMP]}) begin
            f.z = in.wide ? res == 16'h0000 : res[7:0] == 8'h00;
            f.s = r_s;
            f.p = ~^res[7:0];                       // Even parity, low byte
        end
    end

    assign out_valid        = in_valid;
    assign out.dest         = in.dest;
    assign out.writes_reg   = in.writes_reg;
    assign out.wide         = in.wide;
    assign out.high         = in.high;
    assign out.writes_flags = in.writes_flags;
    assign out.data         = res;
    assign out.flags        = f;

    always_comb begin
        if (in_valid) begin
            assert final (!(in.high && in.wide))
                else $error("High-byte target on a word operation");
        end
    end

endmodule

/* reg_writeback.sv */
module reg_writeback
    import isa_pkg::*, pipe_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       in_valid,
    input  exec_item_t in,
    output regfile_t   regs,
    output flags_t     flags,
    output retire_t    retire
);

    logic [15:0] word_old;
    logic [15:0] word_new;
    logic [15:0] word_after;
    flags_t      flags_after;

    assign word_old = regs[in.dest];

    // Byte results land in one half of the home word
    always_comb begin
        if (in.wide) begin
            word_new = in.data;
        end else if (in.high) begin
            word_new = {in.data[7:0], word_old[7:0]};
        end else begin
            word_new = {word_old[15:8], in.data[7:0]};
        end
    end

    assign word_after  = in.writes_reg ? word_new : word_old;
    assign flags_after = in.writes_flags ? in.flags : flags;

    always_ff @(posedge clk) begin
        if (reset) begin
            regs   <= '0;
            flags  <= '0;
            retire <= '0;
        end else begin
            retire.valid <= in_valid;
            if (in_valid) begin
                if (in.writes_reg) begin
                    regs[in.dest] <= word_new;
                end
                flags <= flags_after;
                retire.writes_reg <= in.writes_reg;
                retire.dest       <= in.dest;
                retire.data       <= word_after;
                retire.flags      <= flags_after;   // Full word, changed or not
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        in_valid |-> !$isunknown(in))
        else $error("Unknown payload reaches writeback");

endmodule

/* v33_core.sv */
module v33_core
    import isa_pkg::*, pipe_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  instr_t  instr,
    input  logic    op_valid,
    output logic    op_ready,
    output retire_t retire
);

    logic       dec_valid, x_valid, e_valid, r_valid;
    dec_item_t  dec_item, x_item;
    exec_item_t e_item, r_item;
    regfile_t   regs;
    flags_t     flags;

    instr_decode i_decode (
        .instr     (instr),
        .op_valid  (op_valid),
        .op_ready  (op_ready),
        .regs      (regs),
        .flags     (flags),
        .x_valid   (x_valid),
        .x_dest    (x_item.dest),
        .x_flags   (x_item.writes_flags),
        .r_valid   (r_valid),
        .r_dest    (r_item.dest),
        .r_flags   (r_item.writes_flags),
        .dec_valid (dec_valid),
        .dec       (dec_item)
    );

    pipe_stage #(.payload_t(dec_item_t)) i_dec_reg (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (dec_valid),
        .in_data   (dec_item),
        .out_valid (x_valid),
        .out_data  (x_item)
    );

    alu_exec i_exec (
        .in_valid  (x_valid),
        .in        (x_item),
        .out_valid (e_valid),
        .out       (e_item)
    );

    pipe_stage #(.payload_t(exec_item_t)) i_exec_reg (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (e_valid),
        .in_data   (e_item),
        .out_valid (r_valid),
        .out_data  (r_item)
    );

    reg_writeback i_writeback (
        .clk      (clk),
        .reset    (reset),
        .in_valid (r_valid),
        .in       (r_item),
        .regs     (regs),
        .flags    (flags),
        .retire   (retire)
    );

endmodule

/* tb_v33_core.sv */
module tb_v33_core
    import isa_pkg::*, pipe_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int PERIOD         = 20;
    localparam int READY_TIMEOUT  = 50;
    localparam int RETIRE_TIMEOUT = 50;

    typedef struct packed {
        retire_t     rec;
        logic [63:0] accepted_at;   // ns
    } pending_t;

    logic        clk;
    logic        reset;
    instr_t      instr;
    logic        op_valid;
    logic        op_ready;
    retire_t     retire;
    logic [31:0] rng = 32'hafc0_ec60;
    pending_t    pend_q[$];

    v33_core i_dut (
        .clk      (clk),
        .reset    (reset),
        .instr    (instr),
        .op_valid (op_valid),
        .op_ready (op_ready),
        .retire   (retire)
    );

    always #(PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            stop_with_failure($sformatf("MISMATCH %s: got %h, expected %h", name, got, want));
        end
    endtask

    // Retire record is registered, so look at it mid-cycle
    always @(negedge clk) begin
        pending_t p;
        if (retire.valid) begin
            if (pend_q.size() == 0) begin
                stop_with_failure("retire.valid went high with no instruction in flight");
            end else begin
                p = pend_q.pop_front();
                check_value("retire.writes_reg", retire.writes_reg, p.rec.writes_reg);
                if (p.rec.writes_reg) begin
                    check_value("retire.dest", retire.dest, p.rec.dest);
                    check_value("retire.data", retire.data, p.rec.data);
                end
                check_value("retire.flags", retire.flags, p.rec.flags);
                check_value("retire latency in cycles",
                            ($time - p.accepted_at - PERIOD / 2) / PERIOD, 2);
            end
        end
    end

    initial begin
        int          fd;
        int          n;
        int          waited;
        int          idle;
        string       line;
        logic [7:0]  opc;
        logic [7:0]  mrm;
        logic [15:0] imm;
        logic        wr;
        logic [2:0]  dst;
        logic [15:0] data;
        logic [5:0]  flg;
        logic        accepted;
        pending_t    p;

        clk = 1'b0;
        reset = 1'b1;
        instr = '0;
        op_valid = 1'b0;

        fd = $fopen("v33_golden.txt", "r");
        if (fd == 0) begin
            stop_with_failure("Cannot open v33_golden.txt");
        end

        repeat (4) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_value("op_ready", op_ready, 1'b1);
        check_value("retire.valid", retire.valid, 1'b0);

        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h", opc, mrm, imm, wr, dst, data, flg);
                if (n != 7) begin
                    stop_with_failure({"Malformed line in v33_golden.txt: ", line});
                end
                rng = xorshift32(rng);
                idle = rng[1:0];
                @(negedge clk);
                if (idle > 0) begin
                    op_valid = 1'b0;
                    repeat (idle) @(negedge clk);
                end
                instr = {opc, mrm, imm};
                op_valid = 1'b1;

                accepted = 1'b0;
                waited = 0;
                while (!accepted && waited < READY_TIMEOUT) begin
                    #(PERIOD / 4);
                    accepted = op_ready;    // Settled since the falling edge
                    @(posedge clk);
                    waited++;
                    if (!accepted) begin
                        @(negedge clk);
                    end
                end
                if (!accepted) begin
                    stop_with_failure("Timed out waiting for op_ready");
                end else begin
                    p.rec.valid = 1'b1;
                    p.rec.writes_reg = wr;
                    p.rec.dest = reg16_e'(dst);
                    p.rec.data = data;
                    p.rec.flags = flg;
                    p.accepted_at = $time;
                    pend_q.push_back(p);
                end
            end
        end
        $fclose(fd);

        @(negedge clk);
        op_valid = 1'b0;

        waited = 0;
        while (pend_q.size() != 0 && waited < RETIRE_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (pend_q.size() != 0) begin
            stop_with_failure("Timed out waiting for retire.valid");
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

/* v33_golden.txt */
# opcode modrm imm | writes_reg dest data flags, all hex; flags bits are v s z ac p cy
# dest and data are not checked where writes_reg is 0
b8 00 1234 1 0 1234 00   # MOV AW, 1234h
b9 00 00f0 1 1 00f0 00   # MOV CW, 00F0h
b3 00 007f 1 3 007f 00   # MOV BL, 7Fh
b6 00 0080 1 2 8000 00   # MOV DH, 80h
8a e3 0000 1 0 7f34 00   # MOV AH, BL
88 f1 0000 1 1 0080 00   # MOV CL, DH
8b e0 0000 1 4 7f34 00   # MOV SP, AW
03 c1 0000 1 0 7fb4 02   # ADD AW, CW
04 00 007c 1 0 7f30 07   # ADD AL, 7Ch
08 d9 0000 1 1 00ff 12   # OR CL, BL
0d 00 8000 1 0 ff30 12   # OR AW, 8000h
f9 00 0000 0 0 0000 13   # SET1 CY
13 d3 0000 1 2 8080 14   # ADDC DW, BW
f5 00 0000 0 0 0000 15   # NOT1 CY
14 00 000f 1 0 ff40 04   # ADDC AL, 0Fh
f9 00 0000 0 0 0000 05   # SET1 CY
1b e0 0000 1 4 7ff3 03   # SUBC SP, AW
f8 00 0000 0 0 0000 02   # CLR1 CY
1c 00 0040 1 0 ff00 0a   # SUBC AL, 40h
23 d4 0000 1 2 0080 00   # AND DW, SP
24 00 000f 1 0 ff00 0a   # AND AL, 0Fh
2a ca 0000 1 1 007f 00   # SUB CL, DL
2d 00 0001 1 0 feff 16   # SUB AW, 0001h
33 dc 0000 1 3 7f8c 00   # XOR BW, SP
34 00 00ff 1 0 fe00 0a   # XOR AL, FFh
3a d9 0000 0 0 0000 24   # CMP BL, CL
3d 00 fe00 0 0 0000 0a   # CMP AW, FE00h
b0 00 0085 1 0 fe85 0a   # MOV AL, 85h
98 00 0000 1 0 ff85 0a   # CVTBW
99 00 0000 1 2 ffff 0a   # CVTWL
be 00 7000 1 6 7000 0a   # MOV IX, 7000h
03 f6 0000 1 6 e000 32   # ADD IX, IX

/* sim.f */
isa_pkg.sv
pipe_pkg.sv
pipe_stage.sv
instr_decode.sv
alu_exec.sv
reg_writeback.sv
v33_core.sv
tb_v33_core.sv

/* Bender.yml */
package:
  name: v33_core

sources:
  - isa_pkg.sv
  - pipe_pkg.sv
  - pipe_stage.sv
  - instr_decode.sv
  - alu_exec.sv
  - reg_writeback.sv
  - v33_core.sv
  - target: simulation
    files:
      - tb_v33_core.sv
